// ==== exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu #(
    parameter int mul_step_bits = 2  // 1, 2 or 4
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     abort,
    output logic [exe_pkg::xlen-1:0] alu_result,
    output logic                     alu_complete,
    exe_op_if.alu                    op
);

    localparam int steps = exe_pkg::xlen / mul_step_bits;

    exe_pkg::mul_state_e          state;
    logic [5:0]                   step_cnt;
    logic [2*exe_pkg::xlen-1:0]   mcand;     // shifted left each step
    logic [exe_pkg::xlen-1:0]     mplr;      // shifted right each step
    logic [2*exe_pkg::xlen-1:0]   acc;       // unsigned product
    logic [2*exe_pkg::xlen-1:0]   partial;
    logic [exe_pkg::xlen-1:0]     mulh_corr;
    logic [exe_pkg::xlen-1:0]     simple_res;
    logic [4:0]                   sh;
    logic                         is_mul;

    assign sh     = op.src2[4:0];
    assign is_mul = (op.alu_op == exe_pkg::alu_mul) | (op.alu_op == exe_pkg::alu_mulh) |
                    (op.alu_op == exe_pkg::alu_mulhu);

    // sum of the multiplicand copies selected by the low multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < mul_step_bits; i++) begin
            if (mplr[i])
                partial = partial + (mcand << i);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || abort) begin
            state    <= exe_pkg::mul_idle;
            step_cnt <= '0;
        end else if (op.start) begin
            state    <= is_mul ? exe_pkg::mul_busy : exe_pkg::mul_idle;
            step_cnt <= '0;
        end else if (state == exe_pkg::mul_busy) begin
            step_cnt <= step_cnt + 6'd1;
            if (step_cnt == 6'(steps - 1))
                state <= exe_pkg::mul_done;
        end
    end

    always_ff @(posedge clk) begin
        if (op.start) begin
            mcand <= {{exe_pkg::xlen{1'b0}}, op.src1};
            mplr  <= op.src2;
            acc   <= '0;
        end else if (state == exe_pkg::mul_busy) begin
            acc   <= acc + partial;
            mcand <= mcand << mul_step_bits;
            mplr  <= mplr >> mul_step_bits;
        end
    end

    // signed high word from the unsigned one
    assign mulh_corr = (op.src1[exe_pkg::xlen-1] ? op.src2 : '0) +
                       (op.src2[exe_pkg::xlen-1] ? op.src1 : '0);

    always_comb begin
        case (op.alu_op)
            exe_pkg::alu_add:   simple_res = op.src1 + op.src2;
            exe_pkg::alu_sub:   simple_res = op.src1 - op.src2;
            exe_pkg::alu_slt:   simple_res = {31'b0, $signed(op.src1) < $signed(op.src2)};
            exe_pkg::alu_sltu:  simple_res = {31'b0, op.src1 < op.src2};
            exe_pkg::alu_and:   simple_res = op.src1 & op.src2;
            exe_pkg::alu_or:    simple_res = op.src1 | op.src2;
            exe_pkg::alu_nor:   simple_res = ~(op.src1 | op.src2);
            exe_pkg::alu_xor:   simple_res = op.src1 ^ op.src2;
            exe_pkg::alu_sll:   simple_res = op.src1 << sh;
            exe_pkg::alu_srl:   simple_res = op.src1 >> sh;
            exe_pkg::alu_sra:   simple_res = $unsigned($signed(op.src1) >>> sh);
            exe_pkg::alu_lui:   simple_res = op.src2;
            exe_pkg::alu_mul:   simple_res = acc[exe_pkg::xlen-1:0];
            exe_pkg::alu_mulh:  simple_res = acc[2*exe_pkg::xlen-1:exe_pkg::xlen] - mulh_corr;
            exe_pkg::alu_mulhu: simple_res = acc[2*exe_pkg::xlen-1:exe_pkg::xlen];
            default:            simple_res = '0;
        endcase
    end

    assign alu_result = simple_res;

    // a leftover done state must not count during the start cycle
    assign alu_complete = is_mul ? ((state == exe_pkg::mul_done) & ~op.start) : 1'b1;

endmodule

// ==== exe_mem_req.sv ====
`timescale 1ns/1ps

module exe_mem_req (
    input  logic [exe_pkg::xlen-1:0] alu_result,
    input  logic                     alu_complete,
    input  logic                     ms_allowin,
    input  logic                     ms_ex,
    input  logic                     wb_ex,
    input  logic                     data_sram_addr_ok,
    output logic                     data_sram_req,
    output logic                     data_sram_wr,
    output logic [1:0]               data_sram_size,
    output logic [3:0]               data_sram_wstrb,
    output logic [exe_pkg::xlen-1:0] data_sram_addr,
    output logic [exe_pkg::xlen-1:0] data_sram_wdata,
    output logic                     mem_done,
    output logic                     ale,
    exe_op_if.mem                    op
);

    logic       is_ld;
    logic       is_st;
    logic       is_h;
    logic       is_w;
    logic       need_req;
    logic [1:0] lo;
    logic [7:0] b0;
    logic [15:0] h0;

    assign lo = alu_result[1:0];
    assign b0 = op.rkd_value[7:0];
    assign h0 = op.rkd_value[15:0];

    assign is_ld = (op.mem_op == exe_pkg::mem_ld_b) | (op.mem_op == exe_pkg::mem_ld_bu) |
                   (op.mem_op == exe_pkg::mem_ld_h) | (op.mem_op == exe_pkg::mem_ld_hu) |
                   (op.mem_op == exe_pkg::mem_ld_w);
    assign is_st = (op.mem_op == exe_pkg::mem_st_b) | (op.mem_op == exe_pkg::mem_st_h) |
                   (op.mem_op == exe_pkg::mem_st_w);
    assign is_h  = (op.mem_op == exe_pkg::mem_ld_h) | (op.mem_op == exe_pkg::mem_ld_hu) |
                   (op.mem_op == exe_pkg::mem_st_h);
    assign is_w  = (op.mem_op == exe_pkg::mem_ld_w) | (op.mem_op == exe_pkg::mem_st_w);

    assign need_req = is_ld | is_st;

    // misaligned word or halfword
    assign ale = op.valid & ((is_w & (|lo)) | (is_h & lo[0]));

    always_comb begin
        data_sram_wstrb = 4'b0000;
        if (op.mem_op == exe_pkg::mem_st_w)
            data_sram_wstrb = 4'b1111;
        else if (op.mem_op == exe_pkg::mem_st_h)
            data_sram_wstrb = lo[1] ? 4'b1100 : 4'b0011;
        else if (op.mem_op == exe_pkg::mem_st_b)
            data_sram_wstrb = 4'b0001 << lo;
    end

    always_comb begin
        if (op.mem_op == exe_pkg::mem_st_b)
            data_sram_wdata = {4{b0}};     // byte in every lane
        else if (op.mem_op == exe_pkg::mem_st_h)
            data_sram_wdata = {2{h0}};
        else
            data_sram_wdata = op.rkd_value;
    end

    assign data_sram_size = is_w ? 2'd2 : is_h ? 2'd1 : 2'd0;
    assign data_sram_addr = alu_result;

    // only when mem stage can take the instr in this same cycle
    assign data_sram_req = op.valid & need_req & ms_allowin & alu_complete &
                           ~wb_ex & ~ms_ex & ~ale;
    assign data_sram_wr  = data_sram_req & is_st;

    // nothing to send, dropped access, or request accepted now
    assign mem_done = ~need_req | ale | ms_ex | wb_ex | (data_sram_req & data_sram_addr_ok);

endmodule

// ==== exe_op_if.sv ====
`timescale 1ns/1ps

interface exe_op_if;

    logic                             valid;
    exe_pkg::alu_op_e                 alu_op;
    logic [exe_pkg::xlen-1:0]         src1;
    logic [exe_pkg::xlen-1:0]         src2;
    logic [exe_pkg::xlen-1:0]         rkd_value;  // store data
    exe_pkg::mem_op_e                 mem_op;
    exe_pkg::res_sel_e                res_sel;
    logic                             rf_we;
    logic [exe_pkg::rf_addr_w-1:0]    rf_waddr;
    logic                             start;      // first cycle of a held instruction

    modport stage (
        output valid, alu_op, src1, src2, rkd_value,
        output mem_op, res_sel, rf_we, rf_waddr, start
    );

    modport alu (
        input alu_op, src1, src2, start
    );

    modport mem (
        input valid, mem_op, rkd_value
    );

    modport wb (
        input valid, res_sel, rf_we, rf_waddr
    );

endinterface

// ==== exe_pkg.sv ====
package exe_pkg;

    localparam int xlen      = 32;
    localparam int rf_addr_w = 5;
    localparam int cnt_w     = 64;

    // alu operations, shifts take src2[4:0]
    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_slt   = 4'd2,
        alu_sltu  = 4'd3,
        alu_and   = 4'd4,
        alu_or    = 4'd5,
        alu_nor   = 4'd6,
        alu_xor   = 4'd7,
        alu_sll   = 4'd8,
        alu_srl   = 4'd9,
        alu_sra   = 4'd10,
        alu_lui   = 4'd11,  // passes src2
        alu_mul   = 4'd12,  // low word
        alu_mulh  = 4'd13,  // signed high word
        alu_mulhu = 4'd14   // unsigned high word
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none  = 4'd0,
        mem_ld_b  = 4'd1,
        mem_ld_bu = 4'd2,
        mem_ld_h  = 4'd3,
        mem_ld_hu = 4'd4,
        mem_ld_w  = 4'd5,
        mem_st_b  = 4'd6,
        mem_st_h  = 4'd7,
        mem_st_w  = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        res_alu    = 2'd0,
        res_cnt_lo = 2'd1,
        res_cnt_hi = 2'd2
    } res_sel_e;

    // iterative multiplier control
    typedef enum logic [1:0] {
        mul_idle = 2'd0,
        mul_busy = 2'd1,
        mul_done = 2'd2
    } mul_state_e;

endpackage

// ==== exe_result_sel.sv ====
`timescale 1ns/1ps

module exe_result_sel (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [exe_pkg::xlen-1:0]      alu_result,
    output logic                          rf_we,
    output logic [exe_pkg::rf_addr_w-1:0] rf_waddr,
    output logic [exe_pkg::xlen-1:0]      result,
    exe_op_if.wb                          op
);

    logic [exe_pkg::cnt_w-1:0] stable_cnt;

    // free running, zero in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!resetn)
            stable_cnt <= '0;
        else
            stable_cnt <= stable_cnt + 1'b1;
    end

    always_comb begin
        case (op.res_sel)
            exe_pkg::res_cnt_lo: result = stable_cnt[exe_pkg::xlen-1:0];
            exe_pkg::res_cnt_hi: result = stable_cnt[exe_pkg::cnt_w-1:exe_pkg::xlen];
            default:             result = alu_result;
        endcase
    end

    assign rf_we    = op.rf_we & op.valid;  // no write from an empty stage
    assign rf_waddr = op.rf_waddr;

endmodule

// ==== exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage #(
    parameter int mul_step_bits = 2
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          in_valid,
    input  exe_pkg::alu_op_e              in_alu_op,
    input  logic [exe_pkg::xlen-1:0]      in_src1,
    input  logic [exe_pkg::xlen-1:0]      in_src2,
    input  logic [exe_pkg::xlen-1:0]      in_rkd_value,
    input  exe_pkg::mem_op_e              in_mem_op,
    input  exe_pkg::res_sel_e             in_res_sel,
    input  logic                          in_rf_we,
    input  logic [exe_pkg::rf_addr_w-1:0] in_rf_waddr,
    input  logic                          ms_allowin,
    input  logic                          ms_ex,
    input  logic                          wb_ex,
    input  logic                          data_sram_addr_ok,
    output logic                          allowin,
    output logic                          out_valid,
    output logic                          out_rf_we,
    output logic [exe_pkg::rf_addr_w-1:0] out_rf_waddr,
    output logic [exe_pkg::xlen-1:0]      out_result,
    output exe_pkg::mem_op_e              out_mem_op,
    output logic                          out_ale,
    output logic                          data_sram_req,
    output logic                          data_sram_wr,
    output logic [1:0]                    data_sram_size,
    output logic [3:0]                    data_sram_wstrb,
    output logic [exe_pkg::xlen-1:0]      data_sram_addr,
    output logic [exe_pkg::xlen-1:0]      data_sram_wdata
);

    logic [exe_pkg::xlen-1:0] alu_result;
    logic                     alu_complete;
    logic                     mem_done;

    exe_op_if u_op_if ();

    exe_stage_reg u_stage_reg (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_alu_op    (in_alu_op),
        .in_src1      (in_src1),
        .in_src2      (in_src2),
        .in_rkd_value (in_rkd_value),
        .in_mem_op    (in_mem_op),
        .in_res_sel   (in_res_sel),
        .in_rf_we     (in_rf_we),
        .in_rf_waddr  (in_rf_waddr),
        .ms_allowin   (ms_allowin),
        .wb_ex        (wb_ex),
        .alu_complete (alu_complete),
        .mem_done     (mem_done),
        .allowin      (allowin),
        .out_valid    (out_valid),
        .op           (u_op_if.stage)
    );

    exe_alu #(
        .mul_step_bits (mul_step_bits)
    ) u_alu (
        .clk          (clk),
        .resetn       (resetn),
        .abort        (wb_ex),         // flush kills a running multiply
        .alu_result   (alu_result),
        .alu_complete (alu_complete),
        .op           (u_op_if.alu)
    );

    exe_mem_req u_mem_req (
        .alu_result        (alu_result),
        .alu_complete      (alu_complete),
        .ms_allowin        (ms_allowin),
        .ms_ex             (ms_ex),
        .wb_ex             (wb_ex),
        .data_sram_addr_ok (data_sram_addr_ok),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .mem_done          (mem_done),
        .ale               (out_ale),
        .op                (u_op_if.mem)
    );

    exe_result_sel u_result_sel (
        .clk        (clk),
        .resetn     (resetn),
        .alu_result (alu_result),
        .rf_we      (out_rf_we),
        .rf_waddr   (out_rf_waddr),
        .result     (out_result),
        .op         (u_op_if.wb)
    );

    assign out_mem_op = u_op_if.mem_op;  // mem stage needs the load kind

endmodule

// ==== exe_stage_reg.sv ====
`timescale 1ns/1ps

module exe_stage_reg (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          in_valid,
    input  exe_pkg::alu_op_e              in_alu_op,
    input  logic [exe_pkg::xlen-1:0]      in_src1,
    input  logic [exe_pkg::xlen-1:0]      in_src2,
    input  logic [exe_pkg::xlen-1:0]      in_rkd_value,
    input  exe_pkg::mem_op_e              in_mem_op,
    input  exe_pkg::res_sel_e             in_res_sel,
    input  logic                          in_rf_we,
    input  logic [exe_pkg::rf_addr_w-1:0] in_rf_waddr,
    input  logic                          ms_allowin,
    input  logic                          wb_ex,
    input  logic                          alu_complete,
    input  logic                          mem_done,
    output logic                          allowin,
    output logic                          out_valid,
    exe_op_if.stage                       op
);

    logic                          valid_r;
    logic                          start_r;
    logic                          ready_go;
    logic                          load;
    exe_pkg::alu_op_e              alu_op_r;
    logic [exe_pkg::xlen-1:0]      src1_r;
    logic [exe_pkg::xlen-1:0]      src2_r;
    logic [exe_pkg::xlen-1:0]      rkd_value_r;
    exe_pkg::mem_op_e              mem_op_r;
    exe_pkg::res_sel_e             res_sel_r;
    logic                          rf_we_r;
    logic [exe_pkg::rf_addr_w-1:0] rf_waddr_r;

    assign ready_go  = alu_complete & mem_done;
    assign allowin   = ~valid_r | (ready_go & ms_allowin);
    assign out_valid = valid_r & ready_go & ~wb_ex;  // flushed instr never leaves
    assign load      = in_valid & allowin;

    // a flush also kills whatever decode hands over in the same cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_r <= 1'b0;
            start_r <= 1'b0;
        end else begin
            start_r <= load & ~wb_ex;
            if (wb_ex)
                valid_r <= 1'b0;
            else if (allowin)
                valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            alu_op_r    <= in_alu_op;
            src1_r      <= in_src1;
            src2_r      <= in_src2;
            rkd_value_r <= in_rkd_value;
            mem_op_r    <= in_mem_op;
            res_sel_r   <= in_res_sel;
            rf_we_r     <= in_rf_we;
            rf_waddr_r  <= in_rf_waddr;
        end
    end

    assign op.valid     = valid_r;
    assign op.start     = start_r;
    assign op.alu_op    = alu_op_r;
    assign op.src1      = src1_r;
    assign op.src2      = src2_r;
    assign op.rkd_value = rkd_value_r;
    assign op.mem_op    = mem_op_r;
    assign op.res_sel   = res_sel_r;
    assign op.rf_we     = rf_we_r;
    assign op.rf_waddr  = rf_waddr_r;

endmodule

// ==== run.sh ====
#!/bin/sh
# build the execute stage testbench with verilator, run it and check the log
verilator --binary --timing -Wno-fatal --top-module tb_exe_stage -f tb.f -o sim_exe_stage \
    && ./obj_dir/sim_exe_stage > sim.log 2>&1 \
    && grep -q "^PASS: all tests$" sim.log \
    && { cat sim.log; echo "run passed"; } \
    || { cat sim.log 2>/dev/null; echo "run failed"; exit 1; }

// ==== tb.f ====
exe_pkg.sv
exe_op_if.sv
exe_stage_reg.sv
exe_alu.sv
exe_mem_req.sv
exe_result_sel.sv
exe_stage.sv
tb_exe_stage.sv

// ==== tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage;

    localparam int mul_step_bits = 2;
    localparam int num_instr     = 300;
    localparam int mul_lat       = 32 / mul_step_bits + 1;  // cycles after the start cycle

    typedef struct packed {
        logic [3:0]  alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] rkd;
        logic [3:0]  mem_op;
        logic [1:0]  res_sel;
        logic        rf_we;
        logic [4:0]  waddr;
    } instr_t;

    logic              clk, resetn, in_valid, in_rf_we, ms_allowin, ms_ex, wb_ex;
    logic              data_sram_addr_ok;
    exe_pkg::alu_op_e  in_alu_op;
    exe_pkg::mem_op_e  in_mem_op;
    exe_pkg::res_sel_e in_res_sel;
    logic [31:0]       in_src1, in_src2, in_rkd_value;
    logic [4:0]        in_rf_waddr;
    logic              allowin, out_valid, out_rf_we, out_ale, data_sram_req, data_sram_wr;
    logic [4:0]        out_rf_waddr;
    logic [31:0]       out_result, data_sram_addr, data_sram_wdata;
    exe_pkg::mem_op_e  out_mem_op;
    logic [1:0]        data_sram_size;
    logic [3:0]        data_sram_wstrb;

    logic [31:0] lfsr;
    logic [63:0] cyc;       // cycles since reset, mirrors the stable counter
    int          errors, checks, sent, handed, flushed, age;
    logic        taken, done;
    instr_t      cur;
    instr_t      q[$];      // instruction held in the stage

    exe_stage #(.mul_step_bits(mul_step_bits)) u_exe_stage (.*);

    always #20 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a, b);
        logic [63:0]        pu;
        logic signed [63:0] ps;
        pu = {32'b0, a} * {32'b0, b};
        ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (op)
            exe_pkg::alu_add:   return a + b;
            exe_pkg::alu_sub:   return a - b;
            exe_pkg::alu_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::alu_sltu:  return (a < b) ? 32'd1 : 32'd0;
            exe_pkg::alu_and:   return a & b;
            exe_pkg::alu_or:    return a | b;
            exe_pkg::alu_nor:   return ~(a | b);
            exe_pkg::alu_xor:   return a ^ b;
            exe_pkg::alu_sll:   return a << b[4:0];
            exe_pkg::alu_srl:   return a >> b[4:0];
            exe_pkg::alu_sra:   return $signed(a) >>> b[4:0];
            exe_pkg::alu_lui:   return b;
            exe_pkg::alu_mul:   return pu[31:0];
            exe_pkg::alu_mulh:  return ps[63:32];
            exe_pkg::alu_mulhu: return pu[63:32];
            default:            return 32'h0;
        endcase
    endfunction

    function automatic logic is_mul(input logic [3:0] op);
        return op == exe_pkg::alu_mul || op == exe_pkg::alu_mulh || op == exe_pkg::alu_mulhu;
    endfunction

    function automatic logic is_store(input logic [3:0] m);
        return m == exe_pkg::mem_st_b || m == exe_pkg::mem_st_h || m == exe_pkg::mem_st_w;
    endfunction

    function automatic logic [1:0] size_of(input logic [3:0] m);
        case (m)
            exe_pkg::mem_ld_w, exe_pkg::mem_st_w:                    return 2'd2;
            exe_pkg::mem_ld_h, exe_pkg::mem_ld_hu, exe_pkg::mem_st_h: return 2'd1;
            default:                                                 return 2'd0;
        endcase
    endfunction

    function automatic logic [3:0] strb_of(input logic [3:0] m, input logic [1:0] lo);
        case (m)
            exe_pkg::mem_st_w: return 4'b1111;
            exe_pkg::mem_st_h: return lo[1] ? 4'b1100 : 4'b0011;
            exe_pkg::mem_st_b: return 4'b0001 << lo;
            default:           return 4'b0000;
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    // sample at the falling edge, all inputs settled since the rising edge
    task automatic check_cycle();
        instr_t      hd;
        logic        held, ale, req, rdy, lv;
        logic [31:0] addr, res, wd;
        held = q.size() > 0;
        hd   = cur;
        if (held) begin
            hd = q[0];
            age++;
        end
        addr = alu_model(hd.alu_op, hd.src1, hd.src2);
        ale  = held && ((size_of(hd.mem_op) == 2'd2 && addr[1:0] != 2'd0) ||
                        (size_of(hd.mem_op) == 2'd1 && addr[0]));
        req  = held && hd.mem_op != 4'd0 && !ale && ms_allowin && !wb_ex && !ms_ex;
        rdy  = hd.mem_op == 4'd0 || ale || ms_ex || wb_ex || (req && data_sram_addr_ok);
        if (is_mul(hd.alu_op))
            rdy = rdy && age > mul_lat;
        lv = held && rdy && !wb_ex;
        check("data_sram_req", req, data_sram_req);
        check("data_sram_wr", req && is_store(hd.mem_op), data_sram_wr);
        check("out_valid", lv, out_valid);
        check("allowin", !held || (rdy && ms_allowin), allowin);
        if (req && data_sram_addr_ok) begin
            check("data_sram_addr", addr, data_sram_addr);
            check("data_sram_size", size_of(hd.mem_op), data_sram_size);
            if (is_store(hd.mem_op)) begin
                wd = hd.mem_op == exe_pkg::mem_st_b ? {4{hd.rkd[7:0]}} :
                     hd.mem_op == exe_pkg::mem_st_h ? {2{hd.rkd[15:0]}} : hd.rkd;
                check("data_sram_wstrb", strb_of(hd.mem_op, addr[1:0]), data_sram_wstrb);
                check("data_sram_wdata", wd, data_sram_wdata);
            end
        end
        if (lv && ms_allowin) begin  // handoff to the mem stage
            res = hd.res_sel == 2'd1 ? cyc[31:0] : hd.res_sel == 2'd2 ? cyc[63:32] : addr;
            check("out_result", res, out_result);
            check("out_rf_we", hd.rf_we, out_rf_we);
            check("out_rf_waddr", hd.waddr, out_rf_waddr);
            check("out_ale", ale, out_ale);
            check("out_mem_op", hd.mem_op, out_mem_op);
            void'(q.pop_front());
            handed++;
        end else if (held && wb_ex) begin
            void'(q.pop_front());
            flushed++;
        end
        taken = in_valid && (!held || (rdy && ms_allowin));
        if (taken && !wb_ex) begin  // a flush also drops the incoming one
            q.push_back(cur);
            age = 0;
        end
    endtask

    task automatic new_instr();
        logic [2:0] kind;
        kind        = 3'(lfsr_take(3));
        cur         = '0;
        cur.src1    = lfsr_take(32);
        cur.src2    = lfsr_take(32);
        cur.rkd     = lfsr_take(32);
        cur.rf_we   = lfsr_take(1) != 32'd0;
        cur.waddr   = 5'(lfsr_take(5));
        if (kind < 3'd4)
            cur.alu_op = 4'(lfsr_take(4) % 32'd12);
        else if (kind == 3'd4)
            cur.alu_op = 4'(32'd12 + lfsr_take(2) % 32'd3);
        else if (kind == 3'd5)
            cur.res_sel = 2'(32'd1 + lfsr_take(1));
        else begin
            cur.mem_op = 4'(32'd1 + lfsr_take(3));
            cur.src1   = cur.src1 & 32'hffff_fffc;
            cur.src2   = lfsr_take(1) != 32'd0 ? 32'd0 : lfsr_take(2);  // mostly aligned
        end
    endtask

    task automatic drive_inputs();
        if (!in_valid || taken) begin
            if (sent < num_instr && lfsr_take(2) != 32'd0) begin
                new_instr();
                sent++;
                in_valid     <= 1'b1;
                in_alu_op    <= exe_pkg::alu_op_e'(cur.alu_op);
                in_src1      <= cur.src1;
                in_src2      <= cur.src2;
                in_rkd_value <= cur.rkd;
                in_mem_op    <= exe_pkg::mem_op_e'(cur.mem_op);
                in_res_sel   <= exe_pkg::res_sel_e'(cur.res_sel);
                in_rf_we     <= cur.rf_we;
                in_rf_waddr  <= cur.waddr;
            end else
                in_valid <= 1'b0;
        end
        ms_allowin        <= lfsr_take(2) != 32'd0;
        data_sram_addr_ok <= lfsr_take(1) != 32'd0;
        wb_ex             <= lfsr_take(5) == 32'd0;  // rare flush
        ms_ex             <= lfsr_take(4) == 32'd0;
    endtask

    initial begin
        #(num_instr * 40 * 40);
        $display("timeout: the stage stopped handing off instructions");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        lfsr = 32'h34a2_a3e8;
        cyc  = '0;
        {errors, checks, sent, handed, flushed, age} = '0;
        {taken, done} = 2'b00;
        cur = '0;
        clk = 1'b0;
        resetn = 1'b0;
        {in_valid, in_rf_we, ms_allowin, ms_ex, wb_ex, data_sram_addr_ok} = '0;
        in_alu_op    = exe_pkg::alu_add;
        in_mem_op    = exe_pkg::mem_none;
        in_res_sel   = exe_pkg::res_alu;
        in_src1      = '0;
        in_src2      = '0;
        in_rkd_value = '0;
        in_rf_waddr  = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        while (!done) begin
            @(negedge clk);
            check_cycle();
            cyc++;
            done = sent == num_instr && !in_valid && q.size() == 0;
            if (!done) begin
                @(posedge clk);
                drive_inputs();
            end
        end
        $display("checks %0d errors %0d handed off %0d flushed %0d",
                 checks, errors, handed, flushed);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
